//--- Makefile
TOP = wide_fifo_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f wide_fifo.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^ALL CHECKS PASSED$$'

clean:
	rm -rf obj_dir

//--- asym_dp_ram.sv
`include "wide_fifo_cfg.svh"

module asym_dp_ram (
	input  logic                     wclk,
	input  wide_fifo_pkg::wr_port_t  wr_port,
	input  logic                     rclk,
	input  wide_fifo_pkg::rd_port_t  rd_port,
	output logic [`WF_R_DATA_W-1:0]  rd_data
);
	import wide_fifo_pkg::*;

	logic [`WF_W_DATA_W-1:0] mem [`WF_DEPTH]; // byte wide storage

	w_addr_t wr_addr_bin;
	r_addr_t rd_addr_bin;

	// both ports arrive gray coded
	assign wr_addr_bin = w_addr_t'(gray2bin(gray_t'(wr_port.addr)));
	assign rd_addr_bin = r_addr_t'(gray2bin(gray_t'(rd_port.addr)));

	always_ff @(posedge wclk) begin
		if (wr_port.en) begin
			mem[wr_addr_bin] <= wr_port.data;
		end
	end

	// gather four bytes of one word, byte 0 in the low lane
	always_ff @(posedge rclk) begin
		if (rd_port.en) begin
			for (int i = 0; i < `WF_RATIO; i++) begin
				rd_data[i*`WF_W_DATA_W +: `WF_W_DATA_W] <= mem[{rd_addr_bin, lane_t'(i)}];
			end
		end
	end

	// address comes from wr_ctrl pointer logic
	wr_addr_known: assert property (
		@(posedge wclk) wr_port.en |-> !$isunknown(wr_port.addr)
	) else $error("asym_dp_ram: write address has unknown bits");

endmodule

//--- ptr_sync.sv
`include "wide_fifo_cfg.svh"

module ptr_sync #(
	parameter type ptr_t = logic [`WF_W_ADDR_W:0]
) (
	input  logic clk,   // destination clock
	input  logic rst_n, // reset already synced to clk
	input  ptr_t ptr_in,
	output ptr_t ptr_out
);

	ptr_t ptr_meta; // first stage, may go metastable

	// gray input so only one bit moves per source update
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr_meta <= '0;
			ptr_out  <= '0;
		end else begin
			ptr_meta <= ptr_in;
			ptr_out  <= ptr_meta;
		end
	end

endmodule

//--- rd_ctrl.sv
`include "wide_fifo_cfg.svh"

module rd_ctrl (
	input  logic                     rclk,
	input  logic                     arst_n,
	input  logic                     rd_en,
	input  wide_fifo_pkg::w_ptr_t    w_ptr_gray_sync,
	output logic                     empty,
	output logic                     rd_valid,
	output wide_fifo_pkg::rd_port_t  rd_port,
	output wide_fifo_pkg::r_ptr_t    r_ptr_gray,
	output logic                     r_rst_n
);
	import wide_fifo_pkg::*;

	logic    rst_meta;
	logic    rd_accept;
	w_ptr_t  w_ptr_bin;
	r_ptr_t  w_word_ptr; // whole words written so far
	r_ptr_t  r_ptr_bin;
	r_ptr_t  r_ptr_bin_nxt;

	// release of reset synced to rclk
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			rst_meta <= 1'b0;
			r_rst_n  <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			r_rst_n  <= rst_meta;
		end
	end

	// drop the lane bits so a partial word stays hidden
	assign w_ptr_bin  = gray2bin(w_ptr_gray_sync);
	assign w_word_ptr = r_ptr_t'(w_ptr_bin >> `WF_LOG2_RATIO);
	assign empty      = (w_word_ptr == r_ptr_bin);

	assign rd_accept     = rd_en & ~empty;
	assign r_ptr_bin_nxt = r_ptr_bin + r_ptr_t'(rd_accept);

	always_ff @(posedge rclk or negedge r_rst_n) begin
		if (!r_rst_n) begin
			r_ptr_bin  <= '0;
			r_ptr_gray <= '0;
			rd_valid   <= 1'b0;
		end else begin
			r_ptr_bin  <= r_ptr_bin_nxt;
			r_ptr_gray <= r_ptr_t'(bin2gray(gray_t'(r_ptr_bin_nxt)));
			rd_valid   <= rd_accept; // data lands in the ram output reg on the same edge
		end
	end

	assign rd_port.en   = rd_accept;
	assign rd_port.addr = r_addr_t'(bin2gray(gray_t'(r_ptr_bin[`WF_R_ADDR_W-1:0])));

	// a read accepted on empty would wrap the word count past the depth
	no_valid_after_empty_rd: assert property (
		@(posedge rclk) disable iff (!r_rst_n)
		r_ptr_t'(w_word_ptr - r_ptr_bin) <= r_ptr_t'(`WF_DEPTH >> `WF_LOG2_RATIO)
	) else $error("rd_ctrl: read pointer ran past the write pointer");

	// without a read, empty can only fall as words arrive
	idle_stable: assert property (
		@(posedge rclk) disable iff (!r_rst_n)
		!rd_en |=> ($stable(r_ptr_bin) && !$rose(empty))
	) else $error("rd_ctrl: pointer or empty changed without rd_en");

endmodule

//--- wide_fifo.f
+incdir+.
wide_fifo_pkg.sv
asym_dp_ram.sv
ptr_sync.sv
wr_ctrl.sv
rd_ctrl.sv
wide_fifo.sv
wide_fifo_tb.sv

//--- wide_fifo.sv
`include "wide_fifo_cfg.svh"

module wide_fifo (
	input  logic                     wclk,
	input  logic                     rclk,
	input  logic                     arst_n,
	input  logic                     wr_en,
	input  logic [`WF_W_DATA_W-1:0]  wr_data,
	input  logic                     rd_en,
	output logic                     full,
	output logic                     empty,
	output logic [`WF_R_DATA_W-1:0]  rd_data,
	output logic                     rd_valid
);
	import wide_fifo_pkg::*;

	wr_port_t  wr_port;
	rd_port_t  rd_port;
	w_ptr_t    w_ptr_gray;
	w_ptr_t    w_ptr_gray_sync; // in rclk domain
	r_ptr_t    r_ptr_gray;
	r_ptr_t    r_ptr_gray_sync; // in wclk domain
	logic      w_rst_n;
	logic      r_rst_n;

	wr_ctrl wr_ctrl_inst (
		.wclk            (wclk),
		.arst_n          (arst_n),
		.wr_en           (wr_en),
		.wr_data         (wr_data),
		.r_ptr_gray_sync (r_ptr_gray_sync),
		.full            (full),
		.wr_port         (wr_port),
		.w_ptr_gray      (w_ptr_gray),
		.w_rst_n         (w_rst_n)
	);

	rd_ctrl rd_ctrl_inst (
		.rclk            (rclk),
		.arst_n          (arst_n),
		.rd_en           (rd_en),
		.w_ptr_gray_sync (w_ptr_gray_sync),
		.empty           (empty),
		.rd_valid        (rd_valid),
		.rd_port         (rd_port),
		.r_ptr_gray      (r_ptr_gray),
		.r_rst_n         (r_rst_n)
	);

	// write pointer over to the read side
	ptr_sync #(.ptr_t(w_ptr_t)) w2r_sync_inst (
		.clk     (rclk),
		.rst_n   (r_rst_n),
		.ptr_in  (w_ptr_gray),
		.ptr_out (w_ptr_gray_sync)
	);

	// read pointer back to the write side
	ptr_sync #(.ptr_t(r_ptr_t)) r2w_sync_inst (
		.clk     (wclk),
		.rst_n   (w_rst_n),
		.ptr_in  (r_ptr_gray),
		.ptr_out (r_ptr_gray_sync)
	);

	asym_dp_ram asym_dp_ram_inst (
		.wclk    (wclk),
		.wr_port (wr_port),
		.rclk    (rclk),
		.rd_port (rd_port),
		.rd_data (rd_data)
	);

endmodule

//--- wide_fifo_cfg.svh
`ifndef WIDE_FIFO_CFG_SVH
`define WIDE_FIFO_CFG_SVH

// write side carries single bytes
`define WF_W_DATA_W 8

// read word is four write bytes wide
`define WF_RATIO 4
`define WF_LOG2_RATIO 2

// read word width
`define WF_R_DATA_W (`WF_W_DATA_W * `WF_RATIO)

// byte addressing, 64 bytes of storage
`define WF_W_ADDR_W 6

// word addressing, 16 words
`define WF_R_ADDR_W (`WF_W_ADDR_W - `WF_LOG2_RATIO)

// storage depth counted in bytes
`define WF_DEPTH (1 << `WF_W_ADDR_W)

// widest pointer incl. wrap bit, sizes the gray helpers
`define WF_GRAY_W (`WF_W_ADDR_W + 1)

`endif

//--- wide_fifo_patterns.txt
# columns: test opcode value(hex) count(decimal)
# W bytes from value upward, R words with value as first word (count 0 reads on empty),
# F/E wait up to count cycles for full/empty == value, N idles count cycles, X random phase
1 E 1 20
1 F 0 20
1 R 0 0
1 N 0 5
2 W 11 1
2 W 22 1
2 W 33 1
2 W 44 1
2 E 0 20
2 R 44332211 1
2 E 1 20
3 W 50 3
3 N 0 10
3 E 1 0
3 W 53 1
3 E 0 20
3 R 53525150 1
3 E 1 20
4 W 00 64
4 F 1 5
4 W 40 1
4 E 0 20
4 R 03020100 16
4 E 1 20
5 W 80 64
5 F 1 5
5 R 83828180 1
5 F 0 20
5 W c0 4
5 F 1 5
5 R 87868584 16
5 E 1 20
6 X 0 200

//--- wide_fifo_pkg.sv
`include "wide_fifo_cfg.svh"

package wide_fifo_pkg;

	typedef logic [`WF_W_ADDR_W:0] w_ptr_t; // byte pointer + wrap bit
	typedef logic [`WF_R_ADDR_W:0] r_ptr_t; // word pointer + wrap bit

	typedef logic [`WF_W_ADDR_W-1:0] w_addr_t;
	typedef logic [`WF_R_ADDR_W-1:0] r_addr_t;
	typedef logic [`WF_LOG2_RATIO-1:0] lane_t; // byte lane inside a word
	typedef logic [`WF_GRAY_W-1:0] gray_t;

	// narrow write port into the memory
	typedef struct packed {
		logic en;
		w_addr_t addr; // gray coded
		logic [`WF_W_DATA_W-1:0] data;
	} wr_port_t;

	// wide read port, address only
	typedef struct packed {
		logic en;
		r_addr_t addr; // gray coded
	} rd_port_t;

	// narrower values are zero extended by the caller
	function automatic gray_t bin2gray(input gray_t bin);
		return bin ^ (bin >> 1);
	endfunction

	// bit i is the xor of all gray bits from i upward
	function automatic gray_t gray2bin(input gray_t gray);
		gray_t bin;
		for (int i = 0; i < `WF_GRAY_W; i++) begin
			bin[i] = ^(gray >> i);
		end
		return bin;
	endfunction

endpackage

//--- wide_fifo_tb.sv
`include "wide_fifo_cfg.svh"

module wide_fifo_tb;

	logic                     wclk;
	logic                     rclk;
	logic                     arst_n;
	logic                     wr_en;
	logic [`WF_W_DATA_W-1:0]  wr_data;
	logic                     rd_en;
	logic                     full;
	logic                     empty;
	logic [`WF_R_DATA_W-1:0]  rd_data;
	logic                     rd_valid;

	logic [`WF_W_DATA_W-1:0] sb_q [$]; // bytes accepted by the DUT with the oldest in front
	integer seed = 82;
	int n_checks = 0;
	int n_errors = 0;
	int cycle_cnt = 0;
	int timeout_limit = 0;
	bit rand_done;

	wide_fifo wide_fifo_inst (
		.wclk     (wclk),
		.rclk     (rclk),
		.arst_n   (arst_n),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.full     (full),
		.empty    (empty),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	initial begin
		rclk = 1'b0;
		forever #50 rclk = ~rclk;
	end

	// start offset keeps wclk and rclk edges from ever lining up
	initial begin
		wclk = 1'b0;
		#17;
		forever #65 wclk = ~wclk;
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		n_checks++;
		if (exp_v !== act_v) begin
			n_errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic report_fail(input string msg);
		n_errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic report_test(input int num, input int errs);
		$display("test %0d finished with %0d errors", num, errs);
	endtask

	// first byte written ends up in lane 0
	task automatic pop_word(output logic [31:0] w);
		w = '0;
		if (sb_q.size() < `WF_RATIO) begin
			report_fail("scoreboard holds less than one whole word");
		end else begin
			for (int b = 0; b < `WF_RATIO; b++) begin
				w[b*`WF_W_DATA_W +: `WF_W_DATA_W] = sb_q.pop_front();
			end
		end
	endtask

	// full is stable between wclk edges, so it decides acceptance
	task automatic write_bytes(input logic [7:0] first, input int count);
		@(posedge wclk);
		#10;
		for (int i = 0; i < count; i++) begin
			wr_data = first + 8'(i);
			wr_en   = 1'b1;
			if (!full) sb_q.push_back(wr_data);
			@(posedge wclk);
			#10;
		end
		wr_en = 1'b0;
	endtask

	task automatic wait_full(input logic v, input int limit);
		for (int i = 0; i < limit && full !== v; i++) begin
			@(posedge wclk);
			#10;
		end
		check_val("full", 32'(v), 32'(full));
	endtask

	task automatic wait_empty(input logic v, input int limit);
		for (int i = 0; i < limit && empty !== v; i++) begin
			@(posedge rclk);
			#10;
		end
		check_val("empty", 32'(v), 32'(empty));
	endtask

	task automatic read_on_empty();
		@(posedge rclk);
		#10;
		check_val("empty", 32'd1, 32'(empty));
		check_val("rd_valid", 32'd0, 32'(rd_valid));
		rd_en = 1'b1;
		@(posedge rclk);
		#10;
		rd_en = 1'b0;
		check_val("rd_valid", 32'd0, 32'(rd_valid)); // nothing to return
	endtask

	task automatic read_words(input logic [31:0] first_exp, input int count);
		logic [31:0] exp_w;
		int tries;
		@(posedge rclk);
		#10;
		for (int k = 0; k < count; k++) begin
			tries = 0;
			while (empty && tries < 20) begin
				@(posedge rclk);
				#10;
				tries++;
			end
			if (empty) begin
				report_fail("read gave up because the FIFO stayed empty");
				return;
			end
			pop_word(exp_w);
			rd_en = 1'b1;
			@(posedge rclk);
			#10;
			rd_en = 1'b0;
			if (!rd_valid) begin
				report_fail("rd_valid missing one cycle after an accepted read");
			end else begin
				if (k == 0) check_val("rd_data", first_exp, rd_data);
				check_val("rd_data", exp_w, rd_data);
			end
		end
	endtask

	task automatic random_phase(input int cycles);
		int rw;
		int rr;
		logic [31:0] exp_w;
		bit pending;
		rand_done = 1'b0;
		fork
			begin
				while (1) begin
					@(posedge wclk);
					#10;
					wr_en = 1'b0;
					if (rand_done) break;
					rw = $random(seed);
					if (rw[1:0] != 2'b00 && !full) begin
						wr_data = rw[15:8];
						wr_en   = 1'b1;
						sb_q.push_back(rw[15:8]);
					end
				end
			end
			begin
				pending = 1'b0;
				for (int c = 0; c <= cycles; c++) begin
					@(posedge rclk);
					#10;
					rd_en = 1'b0;
					if (pending) begin
						if (!rd_valid) report_fail("rd_valid missing after a random read");
						else check_val("rd_data", exp_w, rd_data);
					end else begin
						check_val("rd_valid", 32'd0, 32'(rd_valid));
					end
					pending = 1'b0;
					rr = $random(seed);
					if (c < cycles && rr[0] && !empty) begin
						pop_word(exp_w);
						rd_en   = 1'b1;
						pending = 1'b1;
					end
				end
				rand_done = 1'b1;
			end
		join
	endtask

	initial begin
		int fd;
		int n_lines;
		int tnum;
		int cnt;
		int cur_test;
		int test_err0;
		int n_tests;
		logic [31:0] val;
		logic [7:0] op;
		logic [8*160-1:0] line_buf;
		arst_n    = 1'b0;
		wr_en     = 1'b0;
		wr_data   = '0;
		rd_en     = 1'b0;
		n_lines   = 0;
		cur_test  = 0;
		test_err0 = 0;
		n_tests   = 0;

		// first pass only counts pattern lines to size the timeout
		fd = $fopen("wide_fifo_patterns.txt", "r");
		if (fd == 0) begin
			report_fail("pattern file wide_fifo_patterns.txt could not be opened");
		end else begin
			while ($fgets(line_buf, fd) != 0) begin
				if ($sscanf(line_buf, "%d %s %h %d", tnum, op, val, cnt) == 4) n_lines++;
			end
			$fclose(fd);
			fd = $fopen("wide_fifo_patterns.txt", "r");
		end
		timeout_limit = 40 * n_lines + 2000;

		repeat (16) @(posedge rclk);
		#10;
		arst_n = 1'b1;
		repeat (4) @(posedge rclk); // both reset synchronizers released
		#10;

		if (fd != 0) begin
			while ($fgets(line_buf, fd) != 0) begin
				if ($sscanf(line_buf, "%d %s %h %d", tnum, op, val, cnt) == 4) begin
					if (tnum != cur_test) begin
						if (cur_test != 0) report_test(cur_test, n_errors - test_err0);
						cur_test  = tnum;
						test_err0 = n_errors;
						n_tests++;
					end
					case (op)
						"W": write_bytes(val[7:0], cnt);
						"R": begin
							if (cnt == 0) read_on_empty();
							else read_words(val, cnt);
						end
						"F": wait_full(val[0], cnt);
						"E": wait_empty(val[0], cnt);
						"N": begin
							repeat (cnt) @(posedge rclk);
							#10;
						end
						"X": random_phase(cnt);
						default: report_fail("unknown opcode in pattern file");
					endcase
				end
			end
			$fclose(fd);
		end
		if (cur_test != 0) report_test(cur_test, n_errors - test_err0);

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// run limit grows with the pattern count
	initial begin
		wait (timeout_limit != 0);
		while (cycle_cnt < timeout_limit) begin
			@(posedge rclk);
			cycle_cnt++;
		end
		$display("run stopped by timeout after %0d rclk cycles", timeout_limit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- wr_ctrl.sv
`include "wide_fifo_cfg.svh"

module wr_ctrl (
	input  logic                     wclk,
	input  logic                     arst_n,
	input  logic                     wr_en,
	input  logic [`WF_W_DATA_W-1:0]  wr_data,
	input  wide_fifo_pkg::r_ptr_t    r_ptr_gray_sync,
	output logic                     full,
	output wide_fifo_pkg::wr_port_t  wr_port,
	output wide_fifo_pkg::w_ptr_t    w_ptr_gray,
	output logic                     w_rst_n
);
	import wide_fifo_pkg::*;

	logic    rst_meta;
	logic    wr_accept;
	w_ptr_t  w_ptr_bin;
	w_ptr_t  w_ptr_bin_nxt;
	r_ptr_t  r_ptr_bin;
	w_ptr_t  r_ptr_bytes;
	w_ptr_t  fill; // bytes held modulo the pointer range

	// assert async, release after two wclk edges
	always_ff @(posedge wclk or negedge arst_n) begin
		if (!arst_n) begin
			rst_meta <= 1'b0;
			w_rst_n  <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			w_rst_n  <= rst_meta;
		end
	end

	// read pointer counts words, scale to bytes
	assign r_ptr_bin   = r_ptr_t'(gray2bin(gray_t'(r_ptr_gray_sync)));
	assign r_ptr_bytes = {r_ptr_bin, lane_t'(0)};
	assign fill        = w_ptr_bin - r_ptr_bytes;
	assign full        = (fill == w_ptr_t'(`WF_DEPTH));

	assign wr_accept     = wr_en & ~full; // writes while full are dropped
	assign w_ptr_bin_nxt = w_ptr_bin + w_ptr_t'(wr_accept);

	// gray form is registered so the sync sees single bit steps
	always_ff @(posedge wclk or negedge w_rst_n) begin
		if (!w_rst_n) begin
			w_ptr_bin  <= '0;
			w_ptr_gray <= '0;
		end else begin
			w_ptr_bin  <= w_ptr_bin_nxt;
			w_ptr_gray <= bin2gray(w_ptr_bin_nxt);
		end
	end

	assign wr_port.en   = wr_accept;
	assign wr_port.addr = w_addr_t'(bin2gray(gray_t'(w_ptr_bin[`WF_W_ADDR_W-1:0])));
	assign wr_port.data = wr_data;

	// a write past full shows up as a level above the depth
	no_adv_when_full: assert property (
		@(posedge wclk) disable iff (!w_rst_n)
		fill <= w_ptr_t'(`WF_DEPTH)
	) else $error("wr_ctrl: write pointer moved past full");

endmodule
